//--- dmem_arbiter.sv
`timescale 1ns/100ps

module dmem_arbiter #(
    parameter int unsigned DMEM_ADDR_W = 10
) (
    input  logic             clk_i,
    input  logic             rst_ni,

    input  logic             m0_valid_i,
    input  pe_pkg::bus_req_t m0_req_i,
    output logic             m0_ready_o,
    output logic             m0_rsp_valid_o,
    output logic [31:0]      m0_rsp_data_o,

    input  logic             m1_valid_i,
    input  pe_pkg::bus_req_t m1_req_i,
    output logic             m1_ready_o,
    output logic             m1_rsp_valid_o,
    output logic [31:0]      m1_rsp_data_o,

    output logic             dmem_en_o,
    output pe_pkg::mem_req_t dmem_req_o,
    input  logic [31:0]      dmem_rdata_i
);

    logic             last_q;      // Last winner, 1 means master 1
    logic             grant0;
    logic             grant1;
    pe_pkg::bus_req_t win_req;
    logic             rd_valid_q;
    logic             rd_owner_q;

    ////////////////////////////////////////
    // Round-robin grant
    ////////////////////////////////////////

    assign grant0 = m0_valid_i && (!m1_valid_i || last_q);
    assign grant1 = m1_valid_i && (!m0_valid_i || !last_q);

    assign m0_ready_o = grant0;
    assign m1_ready_o = grant1;

    // Starts as if master 1 had won so the CPU goes first
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= 1'b1;
        end else if (grant0 || grant1) begin
            last_q <= grant1;
        end
    end

    ////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////

    assign win_req   = grant1 ? m1_req_i : m0_req_i;
    assign dmem_en_o = grant0 || grant1;

    always_comb begin
        dmem_req_o                       = '0;
        dmem_req_o.addr[DMEM_ADDR_W-1:0] = win_req.addr[DMEM_ADDR_W+1:2];
        dmem_req_o.strb                  = win_req.strb;
        dmem_req_o.wdata                 = win_req.wdata;
    end

    // Owner of the read in flight
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_valid_q <= 1'b0;
            rd_owner_q <= 1'b0;
        end else begin
            rd_valid_q <= dmem_en_o && (win_req.strb == 4'b0000);
            rd_owner_q <= grant1;
        end
    end

    assign m0_rsp_valid_o = rd_valid_q && !rd_owner_q;
    assign m1_rsp_valid_o = rd_valid_q && rd_owner_q;
    assign m0_rsp_data_o  = dmem_rdata_i;
    assign m1_rsp_data_o  = dmem_rdata_i;

    a_one_ready: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(m0_ready_o && m1_ready_o)
    );

endmodule

//--- pe_addr_decoder.sv
`timescale 1ns/100ps

module pe_addr_decoder #(
    parameter int unsigned DMEM_ADDR_W = 10
) (
    input  logic             clk_i,
    input  logic             rst_ni,

    input  logic             cpu_req_valid_i,
    input  pe_pkg::bus_req_t cpu_req_i,
    output logic             cpu_req_ready_o,
    output logic             cpu_rsp_valid_o,
    output logic [31:0]      cpu_rsp_data_o,

    output logic             mem_valid_o,
    output pe_pkg::bus_req_t mem_req_o,
    input  logic             mem_ready_i,
    input  logic             mem_rsp_valid_i,
    input  logic [31:0]      mem_rdata_i,

    output logic             rtc_en_o,
    output logic             plic_en_o,
    output logic             periph_we_o,
    output logic [3:0]       periph_off_o,
    output logic [31:0]      periph_wdata_o,
    input  logic [31:0]      rtc_rdata_i,
    input  logic [31:0]      plic_rdata_i
);

    // Byte offsets that fall inside the data memory window
    localparam logic [31:0] MEM_OFF_MASK = (32'd1 << (DMEM_ADDR_W + 2)) - 32'd1;

    logic [7:0] region;
    logic       hit_dmem;
    logic       hit_rtc;
    logic       hit_plic;
    logic       accept;
    logic       rd_accept;

    logic       rtc_rd_q;
    logic       plic_rd_q;
    logic       unm_rd_q;

    ////////////////////////////////////////
    // Request routing
    ////////////////////////////////////////

    assign region   = cpu_req_i.addr[31:24];
    assign hit_dmem = (region == pe_pkg::REGION_DMEM);
    assign hit_rtc  = (region == pe_pkg::REGION_RTC);
    assign hit_plic = (region == pe_pkg::REGION_PLIC);

    // Only the memory can stall, everything else answers at once
    assign cpu_req_ready_o = hit_dmem ? mem_ready_i : 1'b1;
    assign accept          = cpu_req_valid_i && cpu_req_ready_o;
    assign rd_accept       = accept && (cpu_req_i.strb == 4'b0000);

    always_comb begin
        mem_req_o      = cpu_req_i;
        mem_req_o.addr = cpu_req_i.addr & MEM_OFF_MASK;
    end

    assign mem_valid_o    = cpu_req_valid_i && hit_dmem;
    assign rtc_en_o       = cpu_req_valid_i && hit_rtc;
    assign plic_en_o      = cpu_req_valid_i && hit_plic;
    assign periph_we_o    = |cpu_req_i.strb;
    assign periph_off_o   = cpu_req_i.addr[3:0];
    assign periph_wdata_o = cpu_req_i.wdata;

    ////////////////////////////////////////
    // Read return
    ////////////////////////////////////////

    // Delayed read flags pick the source one cycle later
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rtc_rd_q  <= 1'b0;
            plic_rd_q <= 1'b0;
            unm_rd_q  <= 1'b0;
        end else begin
            rtc_rd_q  <= rd_accept && hit_rtc;
            plic_rd_q <= rd_accept && hit_plic;
            unm_rd_q  <= rd_accept && !hit_dmem && !hit_rtc && !hit_plic;
        end
    end

    assign cpu_rsp_valid_o = rtc_rd_q || plic_rd_q || unm_rd_q || mem_rsp_valid_i;

    always_comb begin
        if (rtc_rd_q) begin
            cpu_rsp_data_o = rtc_rdata_i;
        end else if (plic_rd_q) begin
            cpu_rsp_data_o = plic_rdata_i;
        end else if (mem_rsp_valid_i) begin
            cpu_rsp_data_o = mem_rdata_i;
        end else begin
            cpu_rsp_data_o = 32'h0;   // unmapped reads give zero
        end
    end

    // Covers the memory path through the arbiter as well
    a_rsp_after_read: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        cpu_rsp_valid_o |-> $past(rd_accept)
    );

endmodule

//--- pe_pkg.sv
package pe_pkg;

    ////////////////////////////////////////
    // Bus payloads
    ////////////////////////////////////////

    // Widest data-memory word address the fabric can carry
    localparam int unsigned DMEM_ADDR_W_MAX = 24;

    // CPU and DMA request, strb all zero means read
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] wdata;
    } bus_req_t;

    // Memory side, word addressed
    typedef struct packed {
        logic [DMEM_ADDR_W_MAX-1:0] addr;
        logic [3:0]                 strb;
        logic [31:0]                wdata;
    } mem_req_t;

    ////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////

    // Top address byte of each mapped region
    typedef enum logic [7:0] {
        REGION_DMEM = 8'h01,
        REGION_RTC  = 8'h02,
        REGION_PLIC = 8'h04
    } region_e;

    // RTC byte offsets
    localparam logic [3:0] RTC_MTIME_LO = 4'h0;
    localparam logic [3:0] RTC_MTIME_HI = 4'h4;
    localparam logic [3:0] RTC_CMP_LO   = 4'h8;
    localparam logic [3:0] RTC_CMP_HI   = 4'hc;

    // PLIC byte offsets
    localparam logic [3:0] PLIC_ENABLE  = 4'h0;
    localparam logic [3:0] PLIC_CLAIM   = 4'h4;

endpackage

//--- pe_plic.sv
`timescale 1ns/100ps

module pe_plic (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        en_i,
    input  logic        we_i,
    input  logic [3:0]  off_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    input  logic        irq_i,
    output logic        mei_o
);

    logic        enable_q;
    logic        pending_q;
    logic        claim_rd;
    logic        claim_hit;
    logic [31:0] rdata_q;

    assign claim_rd  = en_i && !we_i && (off_i == pe_pkg::PLIC_CLAIM);
    assign claim_hit = claim_rd && pending_q && enable_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
        end else if (en_i && we_i && (off_i == pe_pkg::PLIC_ENABLE)) begin
            enable_q <= wdata_i[0];
        end
    end

    // Level source, a held line sets pending again after a claim
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= irq_i || (pending_q && !claim_hit);
        end
    end

    assign mei_o = pending_q && enable_q;

    always_ff @(posedge clk_i) begin
        if (claim_rd) begin
            rdata_q <= {31'h0, claim_hit};
        end else if (en_i && !we_i && (off_i == pe_pkg::PLIC_ENABLE)) begin
            rdata_q <= {31'h0, enable_q};
        end else if (en_i && !we_i) begin
            rdata_q <= 32'h0;
        end
    end

    assign rdata_o = rdata_q;

    // Disabling the source silences mei from the next cycle on
    a_no_mei_when_disabled: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (en_i && we_i && (off_i == pe_pkg::PLIC_ENABLE) && !wdata_i[0]) |=> !mei_o
    );

endmodule

//--- pe_rtc.sv
`timescale 1ns/100ps

module pe_rtc (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        en_i,
    input  logic        we_i,
    input  logic [3:0]  off_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output logic        mti_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        mti_q;
    logic [31:0] rdata_q;

    ////////////////////////////////////////
    // Timer state
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= 64'h0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // Compare register written by halves
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= '1;
        end else if (en_i && we_i) begin
            if (off_i == pe_pkg::RTC_CMP_LO) begin
                mtimecmp_q[31:0] <= wdata_i;
            end else if (off_i == pe_pkg::RTC_CMP_HI) begin
                mtimecmp_q[63:32] <= wdata_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mti_q <= 1'b0;
        end else begin
            mti_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign mti_o = mti_q;

    ////////////////////////////////////////
    // Register read
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            case (off_i)
                pe_pkg::RTC_MTIME_LO: rdata_q <= mtime_q[31:0];
                pe_pkg::RTC_MTIME_HI: rdata_q <= mtime_q[63:32];
                pe_pkg::RTC_CMP_LO:   rdata_q <= mtimecmp_q[31:0];
                pe_pkg::RTC_CMP_HI:   rdata_q <= mtimecmp_q[63:32];
                default:              rdata_q <= 32'h0;
            endcase
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- pe_top.sv
`timescale 1ns/100ps

module pe_top #(
    parameter int unsigned DMEM_ADDR_W = 10
) (
    input  logic             clk_i,
    input  logic             rst_ni,

    input  logic             cpu_req_valid_i,
    input  pe_pkg::bus_req_t cpu_req_i,
    output logic             cpu_req_ready_o,
    output logic             cpu_rsp_valid_o,
    output logic [31:0]      cpu_rsp_data_o,

    input  logic             dma_req_valid_i,
    input  pe_pkg::bus_req_t dma_req_i,
    output logic             dma_req_ready_o,
    output logic             dma_rsp_valid_o,
    output logic [31:0]      dma_rsp_data_o,

    output logic             dmem_en_o,
    output pe_pkg::mem_req_t dmem_req_o,
    input  logic [31:0]      dmem_rdata_i,

    input  logic             dma_irq_i,
    output logic             mti_o,
    output logic             mei_o
);

    logic             mem_valid;
    pe_pkg::bus_req_t mem_req;
    logic             mem_ready;
    logic             mem_rsp_valid;
    logic [31:0]      mem_rdata;
    logic             rtc_en;
    logic             plic_en;
    logic             periph_we;
    logic [3:0]       periph_off;
    logic [31:0]      periph_wdata;
    logic [31:0]      rtc_rdata;
    logic [31:0]      plic_rdata;

    pe_addr_decoder #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) i_decoder (
        .clk_i           (clk_i          ),
        .rst_ni          (rst_ni         ),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_req_i       (cpu_req_i      ),
        .cpu_req_ready_o (cpu_req_ready_o),
        .cpu_rsp_valid_o (cpu_rsp_valid_o),
        .cpu_rsp_data_o  (cpu_rsp_data_o ),
        .mem_valid_o     (mem_valid      ),
        .mem_req_o       (mem_req        ),
        .mem_ready_i     (mem_ready      ),
        .mem_rsp_valid_i (mem_rsp_valid  ),
        .mem_rdata_i     (mem_rdata      ),
        .rtc_en_o        (rtc_en         ),
        .plic_en_o       (plic_en        ),
        .periph_we_o     (periph_we      ),
        .periph_off_o    (periph_off     ),
        .periph_wdata_o  (periph_wdata   ),
        .rtc_rdata_i     (rtc_rdata      ),
        .plic_rdata_i    (plic_rdata     )
    );

    pe_rtc i_rtc (
        .clk_i   (clk_i       ),
        .rst_ni  (rst_ni      ),
        .en_i    (rtc_en      ),
        .we_i    (periph_we   ),
        .off_i   (periph_off  ),
        .wdata_i (periph_wdata),
        .rdata_o (rtc_rdata   ),
        .mti_o   (mti_o       )
    );

    pe_plic i_plic (
        .clk_i   (clk_i       ),
        .rst_ni  (rst_ni      ),
        .en_i    (plic_en     ),
        .we_i    (periph_we   ),
        .off_i   (periph_off  ),
        .wdata_i (periph_wdata),
        .rdata_o (plic_rdata  ),
        .irq_i   (dma_irq_i   ),
        .mei_o   (mei_o       )
    );

    // Port 0 is the CPU through the decoder, port 1 the DMA engine
    dmem_arbiter #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) i_arbiter (
        .clk_i          (clk_i          ),
        .rst_ni         (rst_ni         ),
        .m0_valid_i     (mem_valid      ),
        .m0_req_i       (mem_req        ),
        .m0_ready_o     (mem_ready      ),
        .m0_rsp_valid_o (mem_rsp_valid  ),
        .m0_rsp_data_o  (mem_rdata      ),
        .m1_valid_i     (dma_req_valid_i),
        .m1_req_i       (dma_req_i      ),
        .m1_ready_o     (dma_req_ready_o),
        .m1_rsp_valid_o (dma_rsp_valid_o),
        .m1_rsp_data_o  (dma_rsp_data_o ),
        .dmem_en_o      (dmem_en_o      ),
        .dmem_req_o     (dmem_req_o     ),
        .dmem_rdata_i   (dmem_rdata_i   )
    );

endmodule

//--- project.f
pe_pkg.sv
pe_addr_decoder.sv
pe_rtc.sv
pe_plic.sv
dmem_arbiter.sv
pe_top.sv
tb_dmem_model.sv
tb_pe_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_pe_top -f project.f -o sim_pe_top > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_pe_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0

//--- tb_dmem_model.sv
`timescale 1ns/100ps

module tb_dmem_model #(
    parameter int unsigned DMEM_ADDR_W = 10
) (
    input  logic             clk_i,
    input  logic             en_i,
    input  pe_pkg::mem_req_t req_i,
    output logic [31:0]      rdata_o
);

    logic [31:0] mem_q [0:(1 << DMEM_ADDR_W) - 1];

    // Synchronous memory with byte lanes, read data one cycle after enable
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (req_i.strb == 4'b0000) begin
                rdata_o <= mem_q[req_i.addr[DMEM_ADDR_W-1:0]];
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.strb[b]) begin
                        mem_q[req_i.addr[DMEM_ADDR_W-1:0]][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- tb_pe_top.sv
`timescale 1ns/100ps

module tb_pe_top;

    localparam int unsigned DMEM_ADDR_W = 10;
    localparam int unsigned TIMEOUT     = 100;

    // One bus transfer and what it should return
    typedef struct packed {
        logic        dma;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] data;
        logic        exp_rsp;
        logic [31:0] exp_data;
    } entry_t;

    logic             clk_i;
    logic             rst_ni;
    logic             cpu_req_valid_i;
    pe_pkg::bus_req_t cpu_req_i;
    logic             cpu_req_ready_o;
    logic             cpu_rsp_valid_o;
    logic [31:0]      cpu_rsp_data_o;
    logic             dma_req_valid_i;
    pe_pkg::bus_req_t dma_req_i;
    logic             dma_req_ready_o;
    logic             dma_rsp_valid_o;
    logic [31:0]      dma_rsp_data_o;
    logic             dmem_en_o;
    pe_pkg::mem_req_t dmem_req_o;
    logic [31:0]      dmem_rdata_i;
    logic             dma_irq_i;
    logic             mti_o;
    logic             mei_o;

    entry_t      table_q[$];
    logic [31:0] ref_mem [64];
    logic [31:0] lcg_state;
    int unsigned mismatches;
    int unsigned timeouts;

    pe_top #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) i_dut (.*);

    tb_dmem_model #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) i_dmem (
        .clk_i   (clk_i       ),
        .en_i    (dmem_en_o   ),
        .req_i   (dmem_req_o  ),
        .rdata_o (dmem_rdata_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic pe_pkg::bus_req_t make_req(logic [31:0] addr, logic [3:0] strb,
                                                  logic [31:0] data);
        pe_pkg::bus_req_t req;
        req.addr  = addr;
        req.strb  = strb;
        req.wdata = data;
        return req;
    endfunction

    function automatic logic [31:0] dmem_addr(int unsigned word);
        return {pe_pkg::REGION_DMEM, 24'(word * 4)};
    endfunction

    function automatic logic [31:0] periph_addr(logic [7:0] region, logic [3:0] off);
        return {region, 20'h0, off};
    endfunction

    function automatic void add_entry(logic dma, logic [31:0] addr, logic [3:0] strb,
                                      logic [31:0] data, logic exp_rsp, logic [31:0] exp_data);
        entry_t e;
        e.dma      = dma;
        e.addr     = addr;
        e.strb     = strb;
        e.data     = data;
        e.exp_rsp  = exp_rsp;
        e.exp_data = exp_data;
        table_q.push_back(e);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            mismatches++;
        end
    endtask

    // One transfer on either master, waits for ready and then the read response
    task automatic request(input logic dma, input pe_pkg::bus_req_t req, input logic exp_rsp,
                           output logic [31:0] rdata);
        int unsigned cnt;
        rdata = 32'h0;
        @(posedge clk_i);
        #1;
        if (dma) begin
            dma_req_valid_i = 1'b1;
            dma_req_i       = req;
        end else begin
            cpu_req_valid_i = 1'b1;
            cpu_req_i       = req;
        end
        cnt = 0;
        @(negedge clk_i);
        while (!(dma ? dma_req_ready_o : cpu_req_ready_o) && cnt < TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("Timeout: request to address %h was never accepted", req.addr);
            timeouts++;
        end
        @(posedge clk_i);
        #1;
        cpu_req_valid_i = 1'b0;
        dma_req_valid_i = 1'b0;
        if (exp_rsp) begin
            cnt = 0;
            @(negedge clk_i);
            while (!(dma ? dma_rsp_valid_o : cpu_rsp_valid_o) && cnt < TIMEOUT) begin
                @(negedge clk_i);
                cnt++;
            end
            if (cnt >= TIMEOUT) begin
                $display("Timeout: no read response for address %h", req.addr);
                timeouts++;
            end
            rdata = dma ? dma_rsp_data_o : cpu_rsp_data_o;
        end
    endtask

    task automatic write_word(input logic dma, input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        request(dma, make_req(addr, 4'hf, data), 1'b0, unused);
    endtask

    task automatic read_word(input logic dma, input logic [31:0] addr, output logic [31:0] data);
        request(dma, make_req(addr, 4'h0, 32'h0), 1'b1, data);
    endtask

    task automatic wait_irq(input logic use_mei, input logic level, input string what);
        int unsigned cnt;
        cnt = 0;
        @(negedge clk_i);
        while (((use_mei ? mei_o : mti_o) !== level) && cnt < TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("Timeout: %s never went to %0b", what, level);
            timeouts++;
        end
    endtask

    task automatic pulse_irq();
        @(posedge clk_i);
        #1;
        dma_irq_i = 1'b1;
        @(posedge clk_i);
        #1;
        dma_irq_i = 1'b0;
    endtask

    // Both masters write back to back, CPU to words 16.., DMA to words 32..
    task automatic contend(input int unsigned n);
        int unsigned ci;
        int unsigned di;
        int unsigned cnt;
        logic        cpu_acc;
        logic        dma_acc;
        logic        last_dma;
        logic        have_last;
        for (int unsigned i = 0; i < n; i++) begin
            ref_mem[16 + i] = next_rand();
            ref_mem[32 + i] = next_rand();
        end
        ci        = 0;
        di        = 0;
        cnt       = 0;
        last_dma  = 1'b0;
        have_last = 1'b0;
        @(posedge clk_i);
        #1;
        cpu_req_valid_i = 1'b1;
        cpu_req_i       = make_req(dmem_addr(16), 4'hf, ref_mem[16]);
        dma_req_valid_i = 1'b1;
        dma_req_i       = make_req(dmem_addr(32), 4'hf, ref_mem[32]);
        while ((ci < n || di < n) && cnt < TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
            cpu_acc = cpu_req_valid_i && cpu_req_ready_o;
            dma_acc = dma_req_valid_i && dma_req_ready_o;
            // Loser of the last grant must win now
            if (cpu_req_valid_i && dma_req_valid_i && have_last) begin
                check_value(32'({cpu_acc, dma_acc}), 32'({last_dma, !last_dma}),
                            "grant under contention");
            end
            if (cpu_acc || dma_acc) begin
                have_last = 1'b1;
                last_dma  = dma_acc;
            end
            @(posedge clk_i);
            #1;
            if (cpu_acc) begin
                ci++;
                cpu_req_valid_i = (ci < n);
                cpu_req_i       = make_req(dmem_addr(16 + ci), 4'hf, ref_mem[16 + ci]);
            end
            if (dma_acc) begin
                di++;
                dma_req_valid_i = (di < n);
                dma_req_i       = make_req(dmem_addr(32 + di), 4'hf, ref_mem[32 + di]);
            end
        end
        if (ci < n || di < n) begin
            $display("Timeout: contending writes did not all complete");
            timeouts++;
        end
        cpu_req_valid_i = 1'b0;
        dma_req_valid_i = 1'b0;
    endtask

    function automatic void build_table();
        logic [31:0] d;
        for (int unsigned i = 0; i < 8; i++) begin
            d          = next_rand();
            ref_mem[i] = d;
            add_entry(1'b0, dmem_addr(i), 4'hf, d, 1'b0, 32'h0);
        end
        for (int unsigned i = 0; i < 8; i++) begin
            add_entry(1'b0, dmem_addr(i), 4'h0, 32'h0, 1'b1, ref_mem[i]);
        end
        for (int unsigned i = 0; i < 4; i++) begin
            add_entry(1'b1, dmem_addr(i), 4'h0, 32'h0, 1'b1, ref_mem[i]);
        end
        // Unmapped top bytes, low bits alias words 4 and 5
        add_entry(1'b0, 32'h0800_0000, 4'h0, 32'h0, 1'b1, 32'h0);
        add_entry(1'b0, 32'h8000_0010, 4'h0, 32'h0, 1'b1, 32'h0);
        add_entry(1'b0, 32'h0800_0010, 4'hf, next_rand(), 1'b0, 32'h0);
        add_entry(1'b0, 32'h8000_0014, 4'hf, next_rand(), 1'b0, 32'h0);
        add_entry(1'b0, dmem_addr(4), 4'h0, 32'h0, 1'b1, ref_mem[4]);
        add_entry(1'b0, dmem_addr(5), 4'h0, 32'h0, 1'b1, ref_mem[5]);
    endfunction

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        entry_t      e;
        logic [31:0] rdata;
        logic [31:0] t1;
        logic [31:0] t2;
        lcg_state       = 32'h93f3;
        mismatches      = 0;
        timeouts        = 0;
        rst_ni          = 1'b0;
        cpu_req_valid_i = 1'b0;
        cpu_req_i       = '0;
        dma_req_valid_i = 1'b0;
        dma_req_i       = '0;
        dma_irq_i       = 1'b0;
        build_table();
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        @(negedge clk_i);
        check_value(32'(mti_o), 32'd0, "mti_o after reset");
        check_value(32'(mei_o), 32'd0, "mei_o after reset");
        check_value(32'(cpu_rsp_valid_o), 32'd0, "cpu_rsp_valid_o after reset");
        check_value(32'(dma_rsp_valid_o), 32'd0, "dma_rsp_valid_o after reset");
        check_value(32'(dmem_en_o), 32'd0, "dmem_en_o after reset");

        foreach (table_q[i]) begin
            e = table_q[i];
            request(e.dma, make_req(e.addr, e.strb, e.data), e.exp_rsp, rdata);
            if (e.exp_rsp) begin
                check_value(rdata, e.exp_data, $sformatf("read of %h", e.addr));
            end
        end

        // Timer counts, then fires a little after a near compare value
        read_word(1'b0, periph_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIME_LO), t1);
        read_word(1'b0, periph_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIME_LO), t2);
        check_value(32'(t2 > t1), 32'd1, "mtime low advances");
        write_word(1'b0, periph_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_CMP_HI), 32'h0);
        write_word(1'b0, periph_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_CMP_LO), t2 + 32'd40);
        check_value(32'(mti_o), 32'd0, "mti_o before compare time");
        wait_irq(1'b0, 1'b1, "mti_o");
        write_word(1'b0, periph_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_CMP_HI), 32'hffff_ffff);
        write_word(1'b0, periph_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_CMP_LO), 32'hffff_ffff);
        wait_irq(1'b0, 1'b0, "mti_o");

        // External interrupt with enable, claim and disable
        write_word(1'b0, periph_addr(pe_pkg::REGION_PLIC, pe_pkg::PLIC_ENABLE), 32'h1);
        pulse_irq();
        wait_irq(1'b1, 1'b1, "mei_o");
        read_word(1'b0, periph_addr(pe_pkg::REGION_PLIC, pe_pkg::PLIC_CLAIM), rdata);
        check_value(rdata, 32'd1, "first claim");
        check_value(32'(mei_o), 32'd0, "mei_o after claim");
        read_word(1'b0, periph_addr(pe_pkg::REGION_PLIC, pe_pkg::PLIC_CLAIM), rdata);
        check_value(rdata, 32'd0, "second claim");
        write_word(1'b0, periph_addr(pe_pkg::REGION_PLIC, pe_pkg::PLIC_ENABLE), 32'h0);
        pulse_irq();
        repeat (8) begin
            @(negedge clk_i);
            check_value(32'(mei_o), 32'd0, "mei_o with source disabled");
        end

        // Each master reads back the words the other one wrote
        contend(6);
        for (int unsigned i = 0; i < 6; i++) begin
            read_word(1'b1, dmem_addr(16 + i), rdata);
            check_value(rdata, ref_mem[16 + i], "DMA read of CPU word");
            read_word(1'b0, dmem_addr(32 + i), rdata);
            check_value(rdata, ref_mem[32 + i], "CPU read of DMA word");
        end

        $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
